// ==== all.f ====
verilog/coreCompPkg.sv
verilog/pcGen.sv
verilog/forwardMux.sv
verilog/regFile.sv
verilog/frontEndTop.sv
testbench/tbTop.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the front-end testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

# Compile with assertions and timing support
verilator --binary --timing --assert -f all.f --top-module tbTop -Mdir "$OBJ" -o simv
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

# Run, keep the whole output in the log
"./$OBJ/simv" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Result comes from the log only
if grep -q "^Verification passed$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== testbench/tbTop.sv ====
// Testbench with clock, reset, random stimulus, reference model, assertions, watchdog and report
module tbTop;
  timeunit 1ns;
  timeprecision 1ps;
  import coreCompPkg::*;

  localparam int CLK_PERIOD = 8;
  // Test lengths in cycles
  localparam int RST_CYC    = 10;
  localparam int FIRST_CYC  = 6;
  localparam int STEP_CYC   = 200;
  localparam int REDIR_CYC  = 200;
  localparam int RF_CYC     = 400;
  localparam int FWD_CYC    = 300;
  localparam int TEST_NUM   = 5;
  // One extra checking edge per test
  localparam int TOTAL_CYC  = RST_CYC + FIRST_CYC + STEP_CYC + REDIR_CYC + RF_CYC + FWD_CYC
                              + TEST_NUM;
  // Double margin
  localparam int WDOG_NS    = 2 * TOTAL_CYC * CLK_PERIOD;

  // DUT inputs idle at time zero
  logic                               clk       = 1'b0;
  logic                               rst       = 1'b1;
  logic                               stall     = 1'b0;
  logic     [SET_PORT_NUM-1:0]        setEn     = '0;
  word_t    [SET_PORT_NUM-1:0]        setPc     = '0;
  logic     [STEP_W-1:0]              nxtPcStep = '0;
  logic                               wrVld     = 1'b0;
  regAddr_t                           wrRd      = '0;
  word_t                              wrDat     = '0;
  logic                               fwdVld    = 1'b0;
  regAddr_t                           fwdRd     = '0;
  word_t                              fwdDat    = '0;
  regAddr_t [RD_PORT_NUM-1:0]         rs        = '0;
  // DUT outputs
  word_t                              pc;
  word_t                              nxtPc;
  word_t    [RD_PORT_NUM-1:0]         rsDat;
  logic     [RD_PORT_NUM-1:0]         hazard;

  // Model state
  logic                               refFlg;
  word_t                              refPc;
  word_t                              refRegs [REG_NUM];
  word_t                              pcPrev;
  // Model outputs
  word_t                              redirTgt;
  word_t                              expNxtPc;
  word_t    [RD_PORT_NUM-1:0]         expRsDat;
  logic     [RD_PORT_NUM-1:0]         expHazard;

  int errCnt  = 0;
  int passCnt = 0;
  int failCnt = 0;

  //////////////////////////////////////////////////
  // Clock and DUT
  //////////////////////////////////////////////////

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  frontEndTop dut_i (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .setEn     (setEn),
    .setPc     (setPc),
    .nxtPcStep (nxtPcStep),
    .wrVld     (wrVld),
    .wrRd      (wrRd),
    .wrDat     (wrDat),
    .fwdVld    (fwdVld),
    .fwdRd     (fwdRd),
    .fwdDat    (fwdDat),
    .rs        (rs),
    .pc        (pc),
    .nxtPc     (nxtPc),
    .rsDat     (rsDat),
    .hazard    (hazard)
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Walk down so the lowest active port is the last one taken
  always_comb begin
    redirTgt = '0;
    for (int i = SET_PORT_NUM - 1; i >= 0; i--) begin
      if (setEn[i]) begin
        redirTgt = setPc[i];
      end
    end
    if (!refFlg) begin
      expNxtPc = refPc;
    end else if (setEn != '0) begin
      expNxtPc = redirTgt;
    end else begin
      expNxtPc = refPc + word_t'(nxtPcStep);
    end
  end

  // x0 first, then bus match, then stored word
  always_comb begin
    for (int p = 0; p < RD_PORT_NUM; p++) begin
      if (rs[p] == '0) begin
        expRsDat[p]  = '0;
        expHazard[p] = 1'b0;
      end else if (fwdRd == rs[p]) begin
        expRsDat[p]  = fwdDat;
        expHazard[p] = ~fwdVld;
      end else begin
        expRsDat[p]  = refRegs[rs[p]];
        expHazard[p] = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    pcPrev <= refPc;
    if (rst) begin
      refFlg <= 1'b0;
      refPc  <= START_ADDR;
      for (int i = 0; i < REG_NUM; i++) begin
        refRegs[i] <= '0;
      end
    end else begin
      refFlg <= 1'b1;
      if (!stall) begin
        refPc <= expNxtPc;
      end
      // Writes to x0 or with vld low are dropped
      if (wrVld && wrRd != '0) begin
        refRegs[wrRd] <= wrDat;
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic reportMismatch(input string sigName, input word_t expVal, input word_t gotVal);
    errCnt++;
    $display("ERR %0t %s exp %h got %h", $time, sigName, expVal, gotVal);
  endtask

  pcAfterReset: assert property (
    @(posedge clk) $fell(rst) |-> (pc == START_ADDR)
  ) else reportMismatch("pc", START_ADDR, $sampled(pc));

  // Step and redirects masked in the first cycle
  firstCycleHold: assert property (
    @(posedge clk) disable iff (rst) !refFlg |-> (nxtPc == refPc)
  ) else reportMismatch("nxtPc", $sampled(refPc), $sampled(nxtPc));

  pcModel: assert property (
    @(posedge clk) disable iff (rst) pc == refPc
  ) else reportMismatch("pc", $sampled(refPc), $sampled(pc));

  nxtPcModel: assert property (
    @(posedge clk) disable iff (rst) nxtPc == expNxtPc
  ) else reportMismatch("nxtPc", $sampled(expNxtPc), $sampled(nxtPc));

  redirectPrio: assert property (
    @(posedge clk) disable iff (rst) (refFlg && setEn != '0) |-> (nxtPc == redirTgt)
  ) else reportMismatch("nxtPc", $sampled(redirTgt), $sampled(nxtPc));

  stallHold: assert property (
    @(posedge clk) disable iff (rst) stall |=> (pc == pcPrev)
  ) else reportMismatch("pc", $sampled(pcPrev), $sampled(pc));

  for (genvar p = 0; p < RD_PORT_NUM; p++) begin : gPortChk
    rsDatModel: assert property (
      @(posedge clk) disable iff (rst) rsDat[p] == expRsDat[p]
    ) else reportMismatch($sformatf("rsDat[%0d]", p), $sampled(expRsDat[p]),
                          $sampled(rsDat[p]));

    hazardModel: assert property (
      @(posedge clk) disable iff (rst) hazard[p] == expHazard[p]
    ) else reportMismatch($sformatf("hazard[%0d]", p), word_t'($sampled(expHazard[p])),
                          word_t'($sampled(hazard[p])));

    // x0 reads zero even with a matching bus
    x0Reads: assert property (
      @(posedge clk) disable iff (rst) (rs[p] == '0) |-> (rsDat[p] == '0)
    ) else reportMismatch($sformatf("rsDat[%0d]", p), '0, $sampled(rsDat[p]));
  end

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic endTest(input string name, input int errBefore);
    // Last stimulus cycle is checked on this edge
    @(posedge clk);
    #1;
    if (errCnt == errBefore) begin
      passCnt++;
      $display("Test %s: ok", name);
    end else begin
      failCnt++;
      $display("Test %s: FAILED with %0d errors", name, errCnt - errBefore);
    end
  endtask

  task automatic resetTest();
    int errBefore;
    errBefore = errCnt;
    @(posedge clk);
    // Step and redirects already pending when reset drops
    setEn     <= '1;
    nxtPcStep <= STEP_W'($urandom_range(1, 15));
    for (int i = 0; i < SET_PORT_NUM; i++) begin
      setPc[i] <= word_t'($urandom);
    end
    repeat (RST_CYC - 1) @(posedge clk);
    rst <= 1'b0;
    repeat (FIRST_CYC) @(posedge clk);
    endTest("reset and first cycle", errBefore);
  endtask

  task automatic pcTest(input string name, input int cycles, input logic redirect);
    int errBefore;
    errBefore = errCnt;
    repeat (cycles) begin
      @(posedge clk);
      stall     <= ($urandom_range(0, 3) == 0);
      nxtPcStep <= STEP_W'($urandom);
      // Several redirect bits high at once is common here
      setEn     <= redirect ? SET_PORT_NUM'($urandom) : '0;
      for (int i = 0; i < SET_PORT_NUM; i++) begin
        setPc[i] <= word_t'($urandom);
      end
      for (int p = 0; p < RD_PORT_NUM; p++) begin
        rs[p] <= regAddr_t'($urandom);
      end
    end
    endTest(name, errBefore);
  endtask

  task automatic regTest(input string name, input int cycles, input logic fwdHit);
    int       errBefore;
    regAddr_t srcA;
    regAddr_t srcB;
    regAddr_t fwdIdx;
    errBefore = errCnt;
    repeat (cycles) begin
      @(posedge clk);
      srcA   = ($urandom_range(0, 7) == 0) ? '0 : regAddr_t'($urandom);
      srcB   = ($urandom_range(0, 7) == 0) ? '0 : regAddr_t'($urandom);
      fwdIdx = regAddr_t'($urandom);
      if (fwdHit) begin
        case ($urandom_range(0, 3))
          0, 1:    fwdIdx = srcA;
          2:       fwdIdx = srcB;
          default: fwdIdx = regAddr_t'($urandom);
        endcase
      end else begin
        // Bus parked off both sources
        while (fwdIdx == srcA || fwdIdx == srcB) begin
          fwdIdx = fwdIdx + 1'b1;
        end
      end
      wrVld  <= ($urandom_range(0, 4) != 0);
      wrRd   <= ($urandom_range(0, 15) == 0) ? '0 : regAddr_t'($urandom);
      wrDat  <= word_t'($urandom);
      fwdVld <= 1'($urandom);
      fwdRd  <= fwdIdx;
      fwdDat <= word_t'($urandom);
      rs[0]  <= srcA;
      rs[1]  <= srcB;
    end
    endTest(name, errBefore);
  endtask

  initial begin
    void'($urandom(81933));
    resetTest();
    pcTest("step and stall", STEP_CYC, 1'b0);
    pcTest("redirect priority", REDIR_CYC, 1'b1);
    regTest("register write and read", RF_CYC, 1'b0);
    regTest("forwarding", FWD_CYC, 1'b1);
    $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
             passCnt, failCnt, errCnt);
    if (failCnt == 0 && errCnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog over the summed test lengths
  initial begin
    #(WDOG_NS);
    $display("Timeout: run did not finish within %0d ns", WDOG_NS);
    $display("Verification failed");
    $finish;
  end

endmodule : tbTop

// ==== verilog/coreCompPkg.sv ====
// Core front-end package: widths, port counts, reset address, register channel struct
package coreCompPkg;

  //////////////////////////////////////////////////
  // Widths and counts
  //////////////////////////////////////////////////

  // Data and address width
  localparam int XLEN         = 32;
  // Architectural register count
  localparam int REG_NUM      = 32;
  // Index width for REG_NUM entries
  localparam int REG_ADDR_W   = $clog2(REG_NUM);
  // Read ports on the register file
  localparam int RD_PORT_NUM  = 2;
  // Forwarding buses into each read port
  localparam int FWD_PORT_NUM = 1;
  // Redirect ports into the PC generator
  localparam int SET_PORT_NUM = 2;
  // PC increment width
  localparam int STEP_W       = 4;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] regAddr_t;

  // First fetch address out of reset
  localparam word_t START_ADDR = 32'h0000_0200;

  // Write port and forwarding bus share this layout, vld in the top bit
  typedef struct packed {
    logic     vld;
    regAddr_t rd;
    word_t    dat;
  } rfWrChan_t;

endpackage : coreCompPkg

// ==== verilog/forwardMux.sv ====
// Forwarding multiplexer with bus match, register file fallback and data hazard flag
module forwardMux (
  input  coreCompPkg::rfWrChan_t fwdPort,
  input  coreCompPkg::regAddr_t  rs,
  input  coreCompPkg::word_t     rfDat,
  output coreCompPkg::word_t     finalDat,
  output logic                   hazard
);
  import coreCompPkg::*;

  // Forwarding buses in the low bits and register file source on top
  localparam int SEL_W = FWD_PORT_NUM + 1;

  // x0 never forwards and never stalls
  logic                    rsVld;
  logic [FWD_PORT_NUM-1:0] datVld;
  logic [SEL_W-1:0]        selBitmap;
  logic [SEL_W-1:0]        selOh;
  word_t [SEL_W-1:0]       allDat;

  assign rsVld = |rs;

  //////////////////////////////////////////////////
  // Source candidates
  //////////////////////////////////////////////////

  // Forwarding bus hits on a matching destination
  assign datVld[0]    = fwdPort.vld;
  assign selBitmap[0] = (fwdPort.rd == rs) & rsVld;
  assign allDat[0]    = fwdPort.dat;

  // Register file fallback for a live source
  assign selBitmap[FWD_PORT_NUM] = rsVld;
  assign allDat[FWD_PORT_NUM]    = rfDat;

  // Lowest candidate wins, so the bus beats the stored word
  assign selOh = selBitmap & (~selBitmap + SEL_W'(1));

  // Matching bus without data yet
  assign hazard = |(selOh[FWD_PORT_NUM-1:0] & ~datVld);

  //////////////////////////////////////////////////
  // Output mux
  //////////////////////////////////////////////////

  // Nothing selected for x0 gives zero
  always_comb begin
    finalDat = '0;
    for (int i = 0; i < SEL_W; i++) begin
      finalDat = finalDat | (allDat[i] & {XLEN{selOh[i]}});
    end
  end

endmodule : forwardMux

// ==== verilog/frontEndTop.sv ====
// Front-end top: channel packing, PC generator and register file instances
module frontEndTop (
  input  logic                                                 clk,
  input  logic                                                 rst,
  // PC control
  input  logic                                                 stall,
  input  logic                  [coreCompPkg::SET_PORT_NUM-1:0] setEn,
  input  coreCompPkg::word_t    [coreCompPkg::SET_PORT_NUM-1:0] setPc,
  input  logic                  [coreCompPkg::STEP_W-1:0]       nxtPcStep,
  // Register write port
  input  logic                                                 wrVld,
  input  coreCompPkg::regAddr_t                                wrRd,
  input  coreCompPkg::word_t                                   wrDat,
  // Forwarding bus
  input  logic                                                 fwdVld,
  input  coreCompPkg::regAddr_t                                fwdRd,
  input  coreCompPkg::word_t                                   fwdDat,
  // Read sources
  input  coreCompPkg::regAddr_t [coreCompPkg::RD_PORT_NUM-1:0]  rs,
  // Outputs
  output coreCompPkg::word_t                                   pc,
  output coreCompPkg::word_t                                   nxtPc,
  output coreCompPkg::word_t    [coreCompPkg::RD_PORT_NUM-1:0]  rsDat,
  output logic                  [coreCompPkg::RD_PORT_NUM-1:0]  hazard
);
  import coreCompPkg::*;

  rfWrChan_t wrChan;
  rfWrChan_t fwdChan;

  //////////////////////////////////////////////////
  // Channel packing
  //////////////////////////////////////////////////

  assign wrChan  = '{vld: wrVld,  rd: wrRd,  dat: wrDat};
  assign fwdChan = '{vld: fwdVld, rd: fwdRd, dat: fwdDat};

  //////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////

  // Fetch address generation
  pcGen pcGen_i (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .setEn     (setEn),
    .setPc     (setPc),
    .nxtPcStep (nxtPcStep),
    .pc        (pc),
    .nxtPc     (nxtPc)
  );

  // Operand storage with forwarding on both read ports
  regFile regFile_i (
    .clk     (clk),
    .rst     (rst),
    .wrPort  (wrChan),
    .fwdPort (fwdChan),
    .rs      (rs),
    .rsDat   (rsDat),
    .hazard  (hazard)
  );

endmodule : frontEndTop

// ==== verilog/pcGen.sv ====
// Program counter generator: reset flag, priority redirect, step increment, PC register
module pcGen (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic                                              stall,
  input  logic                  [coreCompPkg::SET_PORT_NUM-1:0] setEn,
  input  coreCompPkg::word_t    [coreCompPkg::SET_PORT_NUM-1:0] setPc,
  input  logic                  [coreCompPkg::STEP_W-1:0]       nxtPcStep,
  output coreCompPkg::word_t                                pc,
  output coreCompPkg::word_t                                nxtPc
);
  import coreCompPkg::*;

  // Low in reset and in the first cycle after, high from then on
  logic                    rstFlg;
  // Lowest active redirect, one-hot
  logic [SET_PORT_NUM-1:0] setEnOh;
  word_t                   prioPc;
  logic [STEP_W-1:0]       stepMasked;
  word_t                   nxtStepPc;
  logic                    stepPcVld;

  //////////////////////////////////////////////////
  // Reset flag
  //////////////////////////////////////////////////

  // Stall does not hold the flag back
  always_ff @(posedge clk) begin
    if (rst) begin
      rstFlg <= 1'b0;
    end else begin
      rstFlg <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Next PC selection
  //////////////////////////////////////////////////

  // Isolate lowest set bit, port 0 has top priority
  assign setEnOh = setEn & (~setEn + SET_PORT_NUM'(1));

  // One-hot OR mux over the redirect targets
  always_comb begin
    prioPc = '0;
    for (int i = 0; i < SET_PORT_NUM; i++) begin
      prioPc = prioPc | (setPc[i] & {XLEN{setEnOh[i]}});
    end
  end

  // Step forced to zero until the flag rises
  assign stepMasked = rstFlg ? nxtPcStep : '0;
  // Zero-extended add, wraps at XLEN
  assign nxtStepPc  = pc + word_t'(stepMasked);

  // Redirects ignored in the first cycle as well
  assign stepPcVld = (setEnOh == '0) | ~rstFlg;
  assign nxtPc     = stepPcVld ? nxtStepPc : prioPc;

  //////////////////////////////////////////////////
  // PC register
  //////////////////////////////////////////////////

  // Only back-pressure point of the front end
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= START_ADDR;
    end else if (!stall) begin
      pc <= nxtPc;
    end
  end

  // Stalled cycle keeps fetch address for the next one
  stallHoldsPc: assert property (
    @(posedge clk) disable iff (rst)
    stall |=> $stable(pc)
  ) else $error("pcGen: pc changed under stall");

endmodule : pcGen

// ==== verilog/regFile.sv ====
// Register file with 31 writable registers, hardwired x0, write decode and forwarded read ports
module regFile (
  input  logic                                               clk,
  input  logic                                               rst,
  input  coreCompPkg::rfWrChan_t                             wrPort,
  input  coreCompPkg::rfWrChan_t                             fwdPort,
  input  coreCompPkg::regAddr_t [coreCompPkg::RD_PORT_NUM-1:0] rs,
  output coreCompPkg::word_t    [coreCompPkg::RD_PORT_NUM-1:0] rsDat,
  output logic                  [coreCompPkg::RD_PORT_NUM-1:0] hazard
);
  import coreCompPkg::*;

  // Storage with entry 0 tied off
  word_t                  regs [REG_NUM];
  // Write enable per writable register
  logic  [REG_NUM-1:1]    wrEnOh;
  // Raw stored words before forwarding
  word_t [RD_PORT_NUM-1:0] rfRdDat;

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////

  assign regs[0] = '0;

  for (genvar i = 1; i < REG_NUM; i++) begin : gRfReg
    // Valid-gated decode of the destination index
    assign wrEnOh[i] = wrPort.vld & (wrPort.rd == REG_ADDR_W'(i));

    // Visible on reads one cycle after the write edge
    always_ff @(posedge clk) begin
      if (rst) begin
        regs[i] <= '0;
      end else if (wrEnOh[i]) begin
        regs[i] <= wrPort.dat;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////

  for (genvar p = 0; p < RD_PORT_NUM; p++) begin : gRdPort
    // Combinational index into storage
    assign rfRdDat[p] = regs[rs[p]];

    // Same forwarding bus seen by every port
    forwardMux fwdMux_i (
      .fwdPort  (fwdPort),
      .rs       (rs[p]),
      .rfDat    (rfRdDat[p]),
      .finalDat (rsDat[p]),
      .hazard   (hazard[p])
    );

    // x0 reads zero whatever the forwarding bus carries
    x0ReadsZero: assert property (
      @(posedge clk) disable iff (rst)
      (rs[p] == '0) |-> (rsDat[p] == '0)
    ) else $error("regFile: read of x0 returned a nonzero value");
  end

endmodule : regFile
